//--- design/uart_pkg.sv
// Frame format is fixed at 8N1 with 16 oversample ticks per bit.
// No parity, no word length control and no runtime settings.
package uart_pkg;

  // Data bits per frame, sent and received LSB first
  localparam int data_bits = 8;

  // Oversample ticks per serial bit
  localparam int oversample = 16;

  // Start bit, data bits and one stop bit
  localparam int frame_bits = data_bits + 2;

  // Level of the line between frames and during the stop bit
  localparam logic line_idle = 1'b1;

  // One received word as it leaves the holding register
  typedef struct packed {
    // Received byte
    logic [data_bits-1:0] data;
    // The sampled stop bit was 0
    logic                 frame_err;
    // At least one later byte was dropped while this word waited
    logic                 overrun;
  } rx_word_t;

endpackage

//--- design/uart_sync_flops.sv
// Two flop synchronizer. The second stage only moves on stage1_clk_en_i and
// is held at init_value while stage1_rst_i is high.
`timescale 1ns/100ps

module uart_sync_flops #(
  parameter int width      = 1,
  parameter bit init_value = 1'b1
) (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             stage1_rst_i,
  input  logic             stage1_clk_en_i,
  input  logic [width-1:0] async_dat_i,
  output logic [width-1:0] sync_dat_o
);

  localparam logic [width-1:0] init_vec = {width{init_value}};

  logic [width-1:0] flop_0;
  logic [width-1:0] flop_1;

  // First stage samples the asynchronous input on every clock
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      flop_0 <= init_vec;
    end else begin
      flop_0 <= async_dat_i;
    end
  end

  // Stage-1 reset wins over the enable
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      flop_1 <= init_vec;
    end else if (stage1_rst_i) begin
      flop_1 <= init_vec;
    end else if (stage1_clk_en_i) begin
      flop_1 <= flop_0;
    end
  end

  assign sync_dat_o = flop_1;

endmodule

//--- design/uart_baud_gen.sv
// Free running divider, one tick_o pulse every clk_div clocks.
// clk_div must be at least 2.
`timescale 1ns/100ps

module uart_baud_gen #(
  parameter int clk_div = 16
) (
  input  logic clk_i,
  input  logic arst_n_i,
  output logic tick_o
);

  localparam int cnt_w = $clog2(clk_div);
  localparam logic [cnt_w-1:0] reload = cnt_w'(clk_div - 1);

  logic [cnt_w-1:0] cnt_q;
  logic             tick_q;

  // The first pulse comes clk_div clocks after reset is released
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q  <= reload;
      tick_q <= 1'b0;
    end else if (cnt_q == '0) begin
      cnt_q  <= reload;
      tick_q <= 1'b1;
    end else begin
      cnt_q  <= cnt_q - 1'b1;
      tick_q <= 1'b0;
    end
  end

  // Receiver and transmitter share this time base
  assign tick_o = tick_q;

endmodule

//--- design/uart_rx.sv
// 8N1 receiver with a one word holding register. line_i must already be
// synchronized and sampled on tick_i; a dropped byte sets overrun in the held word.
`timescale 1ns/100ps

module uart_rx (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    rx_en_i,
  input  logic                    tick_i,
  input  logic                    line_i,
  output logic                    rx_valid_o,
  output uart_pkg::rx_word_t      rx_o,
  input  logic                    rx_ready_i
);

  import uart_pkg::*;

  localparam int tick_w = $clog2(oversample);
  localparam int bit_w  = $clog2(data_bits);
  localparam logic [tick_w-1:0] half_tick = tick_w'(oversample / 2 - 1);
  localparam logic [tick_w-1:0] last_tick = tick_w'(oversample - 1);
  localparam logic [bit_w-1:0]  last_bit  = bit_w'(data_bits - 1);

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_data,
    st_stop
  } rx_state_t;

  rx_state_t            state_q;
  logic [tick_w-1:0]    tick_cnt_q;
  logic [bit_w-1:0]     bit_cnt_q;
  logic [data_bits-1:0] shift_q;
  rx_word_t             word_q;
  logic                 valid_q;
  logic                 bit_end;
  logic                 done;
  logic                 take;

  // Tick that closes a full bit period
  assign bit_end = rx_en_i && tick_i && (tick_cnt_q == last_tick);

  // Stop bit sampled, a frame is complete
  assign done = bit_end && (state_q == st_stop);
  assign take = valid_q && rx_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= st_idle;
      tick_cnt_q <= '0;
      bit_cnt_q  <= '0;
    end else if (!rx_en_i) begin
      state_q <= st_idle;
    end else if (tick_i) begin
      case (state_q)
        st_idle: begin
          if (!line_i) begin
            state_q    <= st_start;
            tick_cnt_q <= '0;
          end
        end
        st_start: begin
          // A glitch that has gone high again by mid start bit is ignored
          if (tick_cnt_q == half_tick) begin
            tick_cnt_q <= '0;
            bit_cnt_q  <= '0;
            state_q    <= line_i ? st_idle : st_data;
          end else begin
            tick_cnt_q <= tick_cnt_q + 1'b1;
          end
        end
        st_data: begin
          if (tick_cnt_q == last_tick) begin
            tick_cnt_q <= '0;
            if (bit_cnt_q == last_bit) begin
              state_q <= st_stop;
            end else begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
            end
          end else begin
            tick_cnt_q <= tick_cnt_q + 1'b1;
          end
        end
        st_stop: begin
          if (tick_cnt_q == last_tick) begin
            state_q <= st_idle;
          end else begin
            tick_cnt_q <= tick_cnt_q + 1'b1;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // Data arrives LSB first, so shift in from the top
  always_ff @(posedge clk_i) begin
    if (bit_end && (state_q == st_data)) begin
      shift_q <= {line_i, shift_q[data_bits-1:1]};
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (done) begin
      valid_q <= 1'b1;
    end else if (take) begin
      valid_q <= 1'b0;
    end
  end

  // A frame finishing on the handshake edge replaces the word cleanly.
  // Otherwise it is dropped and only the overrun flag of the held word rises
  always_ff @(posedge clk_i) begin
    if (done && (!valid_q || take)) begin
      word_q.data      <= shift_q;
      word_q.frame_err <= ~line_i;
      word_q.overrun   <= 1'b0;
    end else if (done) begin
      word_q.overrun <= 1'b1;
    end
  end

  assign rx_valid_o = valid_q;
  assign rx_o       = word_q;

endmodule

//--- design/uart_tx.sv
// 8N1 transmitter, one byte in flight. tx_data_i must stay stable while
// tx_valid_i is high and tx_ready_o is low.
`timescale 1ns/100ps

module uart_tx (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          tick_i,
  input  logic                          tx_valid_i,
  input  logic [uart_pkg::data_bits-1:0] tx_data_i,
  output logic                          tx_ready_o,
  output logic                          serial_o
);

  import uart_pkg::*;

  localparam int tick_w = $clog2(oversample);
  localparam int bit_w  = $clog2(frame_bits);
  localparam logic [tick_w-1:0] last_tick = tick_w'(oversample - 1);
  localparam logic [bit_w-1:0]  last_bit  = bit_w'(frame_bits - 1);

  typedef enum logic [1:0] {
    st_idle,
    st_wait,
    st_send
  } tx_state_t;

  tx_state_t          state_q;
  logic [tick_w-1:0]  tick_cnt_q;
  logic [bit_w-1:0]   bit_cnt_q;
  // Data bits followed by the stop level and shifted out from bit 0
  logic [data_bits:0] shift_q;
  logic               serial_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= st_idle;
      tick_cnt_q <= '0;
      bit_cnt_q  <= '0;
      serial_q   <= line_idle;
    end else begin
      case (state_q)
        st_idle: begin
          if (tx_valid_i) begin
            state_q <= st_wait;
          end
        end
        st_wait: begin
          // Align the start bit with the shared tick
          if (tick_i) begin
            serial_q   <= ~line_idle;
            tick_cnt_q <= '0;
            bit_cnt_q  <= '0;
            state_q    <= st_send;
          end
        end
        st_send: begin
          if (tick_i) begin
            if (tick_cnt_q == last_tick) begin
              tick_cnt_q <= '0;
              if (bit_cnt_q == last_bit) begin
                state_q <= st_idle;
              end else begin
                serial_q  <= shift_q[0];
                bit_cnt_q <= bit_cnt_q + 1'b1;
              end
            end else begin
              tick_cnt_q <= tick_cnt_q + 1'b1;
            end
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // The byte is captured on the handshake and the stop level fills in behind it
  always_ff @(posedge clk_i) begin
    if ((state_q == st_idle) && tx_valid_i) begin
      shift_q <= {line_idle, tx_data_i};
    end else if ((state_q == st_send) && tick_i && (tick_cnt_q == last_tick)) begin
      shift_q <= {line_idle, shift_q[data_bits:1]};
    end
  end

  assign tx_ready_o = (state_q == st_idle);
  assign serial_o   = serial_q;

endmodule

//--- design/uart_top.sv
// UART core top. Bit rate is clk_i / (clk_div * 16) and fixed at build time.
// serial_rx_i may be fully asynchronous to clk_i.
`timescale 1ns/100ps

module uart_top #(
  parameter int clk_div = 16
) (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          rx_en_i,
  input  logic                          serial_rx_i,
  input  logic                          tx_valid_i,
  input  logic [uart_pkg::data_bits-1:0] tx_data_i,
  output logic                          tx_ready_o,
  output logic                          rx_valid_o,
  output uart_pkg::rx_word_t            rx_o,
  input  logic                          rx_ready_i,
  output logic                          serial_tx_o
);

  logic tick;
  logic stage1_rst;
  logic line_sync;

  // Hold the synchronizer at the idle level while the receiver is off
  assign stage1_rst = ~rx_en_i;

  uart_baud_gen #(
    .clk_div (clk_div)
  ) uart_baud_gen_inst (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .tick_o   (tick)
  );

  uart_sync_flops #(
    .width      (1),
    .init_value (1'b1)
  ) uart_sync_flops_inst (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .stage1_rst_i    (stage1_rst),
    .stage1_clk_en_i (tick),
    .async_dat_i     (serial_rx_i),
    .sync_dat_o      (line_sync)
  );

  uart_rx uart_rx_inst (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .rx_en_i    (rx_en_i),
    .tick_i     (tick),
    .line_i     (line_sync),
    .rx_valid_o (rx_valid_o),
    .rx_o       (rx_o),
    .rx_ready_i (rx_ready_i)
  );

  uart_tx uart_tx_inst (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .tick_i     (tick),
    .tx_valid_i (tx_valid_i),
    .tx_data_i  (tx_data_i),
    .tx_ready_o (tx_ready_o),
    .serial_o   (serial_tx_o)
  );

endmodule

//--- verification/uart_clk_gen.sv
// Free running testbench clock that starts low
`timescale 1ns/100ps

module uart_clk_gen #(
  parameter int period_ns = 100
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(period_ns / 2);
      clk_o = ~clk_o;
    end
  end

endmodule

//--- verification/uart_sync_flops_chk.sv
// Concurrent checks on the receive line synchronizer.
// Bound into uart_sync_flops and reaches its internal first flop.
`timescale 1ns/100ps

module uart_sync_flops_chk #(
  parameter int width      = 1,
  parameter bit init_value = 1'b1
) (
  input logic             clk_i,
  input logic             arst_n_i,
  input logic             stage1_rst_i,
  input logic             stage1_clk_en_i,
  input logic [width-1:0] async_dat_i,
  input logic [width-1:0] flop_0_i,
  input logic [width-1:0] sync_dat_i
);

  localparam logic [width-1:0] init_vec = {width{init_value}};

  a_init_in_reset : assert property (@(posedge clk_i) !arst_n_i |=> sync_dat_i == init_vec)
    else $error("Synchronizer output left its init value during reset");

  a_init_stage1_rst : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    stage1_rst_i |=> sync_dat_i == init_vec)
    else $error("Synchronizer output not at init value after a stage-1 reset");

  a_first_follows : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    1'b1 |=> flop_0_i == $past(async_dat_i))
    else $error("First flop did not follow the asynchronous input");

  // The second stage moves only on the oversample tick
  a_enable_transfer : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (!stage1_rst_i && stage1_clk_en_i) |=> sync_dat_i == $past(flop_0_i))
    else $error("Second stage did not take the first flop on the enable");

  a_hold_between : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (!stage1_rst_i && !stage1_clk_en_i) |=> $stable(sync_dat_i))
    else $error("Second stage changed between enables");

endmodule

//--- verification/uart_tb.sv
// UART testbench. Reads verification/uart_vectors.txt, so it must run from the project root.
// Bit time is 64 clocks with clk_div 4.
`timescale 1ns/100ps

module uart_tb;

  import uart_pkg::*;

  localparam int clk_div  = 4;
  localparam int bit_clks = clk_div * oversample;
  localparam int wait_max = 20 * bit_clks;

  logic                 clk;
  logic                 arst_n;
  logic                 rx_en;
  logic                 serial_rx;
  logic                 tx_valid;
  logic [data_bits-1:0] tx_data;
  logic                 tx_ready;
  logic                 rx_valid;
  rx_word_t             rx_word;
  logic                 rx_ready;
  logic                 serial_tx;
  logic                 loopback;
  logic                 bang_q;
  int                   errors;
  int                   timeouts;

  uart_clk_gen #(.period_ns(100)) uart_clk_gen_inst (.clk_o(clk));

  uart_top #(.clk_div(clk_div)) uart_top_inst (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .rx_en_i     (rx_en),
    .serial_rx_i (serial_rx),
    .tx_valid_i  (tx_valid),
    .tx_data_i   (tx_data),
    .tx_ready_o  (tx_ready),
    .rx_valid_o  (rx_valid),
    .rx_o        (rx_word),
    .rx_ready_i  (rx_ready),
    .serial_tx_o (serial_tx)
  );

  bind uart_sync_flops uart_sync_flops_chk #(
    .width      (width),
    .init_value (init_value)
  ) uart_sync_flops_chk_inst (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .stage1_rst_i    (stage1_rst_i),
    .stage1_clk_en_i (stage1_clk_en_i),
    .async_dat_i     (async_dat_i),
    .flop_0_i        (flop_0),
    .sync_dat_i      (sync_dat_o)
  );

  // The line model either loops the transmitter back or drives a bit-banged level
  always @(posedge clk) begin
    serial_rx <= loopback ? serial_tx : bang_q;
  end

  task automatic check_value(string name, logic [7:0] exp, logic [7:0] got);
    assert (got == exp) else begin
      $display("Error %s exp %h got %h", name, exp, got);
      errors++;
    end
  endtask

  task automatic report_timeout(string what);
    $display("Timed out while waiting for %s", what);
    timeouts++;
  endtask

  task automatic send_tx_byte(logic [7:0] b);
    int n;
    n = 0;
    @(posedge clk);
    tx_data  <= b;
    tx_valid <= 1'b1;
    @(negedge clk);
    while (!tx_ready && n < wait_max) begin
      @(negedge clk);
      n++;
    end
    if (!tx_ready) report_timeout("tx_ready_o to accept a byte");
    @(posedge clk);
    tx_valid <= 1'b0;
  endtask

  // Samples serial_tx_o in the middle of every bit from the start bit to the stop bit
  task automatic check_tx_frame(logic [7:0] b);
    logic [frame_bits-1:0] frame;
    int n;
    frame = {1'b1, b, 1'b0};
    n = 0;
    @(negedge clk);
    while (serial_tx && n < wait_max) begin
      @(negedge clk);
      n++;
    end
    if (serial_tx) begin
      report_timeout("a start bit on serial_tx_o");
    end else begin
      repeat (bit_clks / 2) @(negedge clk);
      for (int i = 0; i < frame_bits; i++) begin
        check_value("serial_tx_o", 8'(frame[i]), 8'(serial_tx));
        check_value("tx_ready_o", 8'h00, 8'(tx_ready));
        repeat (bit_clks) @(negedge clk);
      end
    end
  endtask

  task automatic bang_frame(logic [7:0] b, logic stop);
    logic [frame_bits-1:0] frame;
    frame = {stop, b, 1'b0};
    for (int i = 0; i < frame_bits - 1; i++) begin
      @(posedge clk);
      bang_q <= frame[i];
      repeat (bit_clks - 1) @(posedge clk);
    end
    // The stop level lasts three quarters of a bit so that the tail of a
    // 0 stop bit is rejected as a false start
    @(posedge clk);
    bang_q <= stop;
    repeat (bit_clks * 3 / 4 - 1) @(posedge clk);
    bang_q <= 1'b1;
    repeat (bit_clks / 4) @(posedge clk);
  endtask

  task automatic take_rx_word(logic [7:0] exp_data, logic [1:0] exp_flags);
    int n;
    n = 0;
    @(negedge clk);
    while (!rx_valid && n < wait_max) begin
      @(negedge clk);
      n++;
    end
    if (!rx_valid) begin
      report_timeout("rx_valid_o");
    end else begin
      // The word is checked after a random stall before it is taken
      repeat ($urandom_range(0, 40)) @(negedge clk);
      check_value("rx_valid_o", 8'h01, 8'(rx_valid));
      check_value("rx_o.data", exp_data, rx_word.data);
      check_value("rx_o.frame_err", 8'(exp_flags[1]), 8'(rx_word.frame_err));
      check_value("rx_o.overrun", 8'(exp_flags[0]), 8'(rx_word.overrun));
      @(posedge clk);
      rx_ready <= 1'b1;
      @(posedge clk);
      rx_ready <= 1'b0;
      @(negedge clk);
      check_value("rx_valid_o", 8'h00, 8'(rx_valid));
    end
  endtask

  task automatic expect_no_rx(int clks);
    for (int i = 0; i < clks; i++) begin
      @(negedge clk);
      check_value("rx_valid_o", 8'h00, 8'(rx_valid));
    end
  endtask

  // Mode 0 is loopback, 1 a bit-banged frame, 2 two frames under stall and 3 the receiver off
  task automatic run_case(int mode, logic [7:0] b, logic stop, logic [7:0] exp_data,
                          logic [1:0] exp_flags);
    repeat (bit_clks / 2 + $urandom_range(0, 100)) @(posedge clk);
    case (mode)
      0: begin
        @(posedge clk);
        loopback <= 1'b1;
        send_tx_byte(b);
        check_tx_frame(b);
        take_rx_word(exp_data, exp_flags);
        @(posedge clk);
        loopback <= 1'b0;
      end
      1: begin
        bang_frame(b, stop);
        take_rx_word(exp_data, exp_flags);
      end
      2: begin
        bang_frame(b, stop);
        repeat (bit_clks / 2 + $urandom_range(0, 50)) @(posedge clk);
        bang_frame(~b, stop);
        take_rx_word(exp_data, exp_flags);
      end
      3: begin
        @(posedge clk);
        rx_en <= 1'b0;
        fork
          bang_frame(b, stop);
          expect_no_rx((frame_bits + 1) * bit_clks);
        join
        @(posedge clk);
        rx_en <= 1'b1;
      end
      default: begin
        $display("Unknown mode %0d in the vector file", mode);
        errors++;
      end
    endcase
  endtask

  initial begin
    int                   fd;
    int                   mode;
    string                line_s;
    logic                 stop;
    logic [data_bits-1:0] tx_byte;
    logic [data_bits-1:0] exp_data;
    logic [1:0]           exp_flags;
    errors    = 0;
    timeouts  = 0;
    arst_n    = 1'b0;
    rx_en     = 1'b1;
    serial_rx = 1'b1;
    tx_valid  = 1'b0;
    tx_data   = '0;
    rx_ready  = 1'b0;
    loopback  = 1'b0;
    bang_q    = 1'b1;
    void'($urandom(32'h4918b8af));

    repeat (15) @(posedge clk);
    @(negedge clk);
    check_value("tx_ready_o", 8'h01, 8'(tx_ready));
    check_value("serial_tx_o", 8'h01, 8'(serial_tx));
    check_value("rx_valid_o", 8'h00, 8'(rx_valid));
    @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_value("tx_ready_o", 8'h01, 8'(tx_ready));
    check_value("serial_tx_o", 8'h01, 8'(serial_tx));
    check_value("rx_valid_o", 8'h00, 8'(rx_valid));

    fd = $fopen("verification/uart_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line_s = "";
        void'($fgets(line_s, fd));
        if ($sscanf(line_s, "%d %h %h %h %h", mode, tx_byte, stop, exp_data,
                    exp_flags) == 5) begin
          run_case(mode, tx_byte, stop, exp_data, exp_flags);
        end
      end
      $fclose(fd);
    end

    $display("Failed checks: %0d  Timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- verification/uart_vectors.txt
# mode byte stop exp_data exp_flags; mode decimal, the rest hex, flags = {frame_err, overrun}
# mode 0 loopback, 1 bit-banged frame, 2 two frames while stalled, 3 frame with receiver off
0 a5 1 a5 0
0 00 1 00 0
0 ff 1 ff 0
0 3c 1 3c 0
1 5a 1 5a 0
1 81 0 81 2
1 c3 1 c3 0
2 12 1 12 1
1 e7 1 e7 0
2 ab 0 ab 3
1 7e 1 7e 0
3 44 1 44 0
1 69 1 69 0
3 0f 0 0f 0
0 96 1 96 0
1 01 1 01 0
0 b2 1 b2 0

//--- vlog.f
design/uart_pkg.sv
design/uart_sync_flops.sv
design/uart_baud_gen.sv
design/uart_rx.sv
design/uart_tx.sv
design/uart_top.sv
verification/uart_clk_gen.sv
verification/uart_sync_flops_chk.sv
verification/uart_tb.sv

//--- Makefile
TOP := uart_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
